// ==== Makefile ====
# Verilator build and run for the multiply/divide unit

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= md_unit_tb
DUT_TOP   ?= md_unit
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

# Pass or fail comes from the log, not from the simulator exit status
run: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -qx "all tests passed" $(LOG) || { echo "simulation did not pass"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/md_arith.sv ====
`timescale 1ns/1ps
`include "md_settings.svh"

module md_arith import md_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  md_req_t    req,
	output md_result_t pending
);

	logic signed [2*`MD_XLEN-1:0] prod_s;
	logic        [2*`MD_XLEN-1:0] prod_u;
	logic signed [`MD_XLEN-1:0]   quo_s;
	logic signed [`MD_XLEN-1:0]   rem_s;
	logic        [`MD_XLEN-1:0]   quo_u;
	logic        [`MD_XLEN-1:0]   rem_u;
	md_result_t                   result;

	// Full-width products
	assign prod_s = $signed(req.a) * $signed(req.b);
	assign prod_u = {{`MD_XLEN{1'b0}}, req.a} * {{`MD_XLEN{1'b0}}, req.b};

	// Quotient and remainder, signed rounds toward zero
	assign quo_s = $signed(req.a) / $signed(req.b);
	assign rem_s = $signed(req.a) % $signed(req.b);
	assign quo_u = req.a / req.b;
	assign rem_u = req.a % req.b;

	always_comb begin
		result = pending;
		case (req.op)
			op_mult:  result = {prod_s[2*`MD_XLEN-1:`MD_XLEN], prod_s[`MD_XLEN-1:0]};
			op_multu: result = {prod_u[2*`MD_XLEN-1:`MD_XLEN], prod_u[`MD_XLEN-1:0]};
			op_div:   result = {rem_s, quo_s};
			op_divu:  result = {rem_u, quo_u};
			default:  result = pending;
		endcase
	end

	// Pending pair, becomes visible only at commit
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
		end else if (start) begin
			pending <= result;
		end
	end

	////////////////////////////////
	// Checks
	////////////////////////////////

	// Zero divisor has no defined result
	a_div_nonzero: assert property (
		@(posedge clk) disable iff (rst)
		start && (req.op == op_div || req.op == op_divu) |-> req.b != '0
	) else $error("divide started with a zero divisor");

endmodule

// ==== design/md_busy_timer.sv ====
`timescale 1ns/1ps
`include "md_settings.svh"

module md_busy_timer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   load,
	input  logic [`MD_TIMER_W-1:0] load_len,
	output logic                   last
);

	logic [`MD_TIMER_W-1:0] count;

	// Loadable down-counter, parks at zero
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (load) begin
			count <= load_len;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// Final busy cycle
	assign last = (count == `MD_TIMER_W'(1));

	////////////////////////////////
	// Checks
	////////////////////////////////

	// The controller must wait for the previous run to drain
	a_no_reload: assert property (
		@(posedge clk) disable iff (rst)
		load |-> count == '0
	) else $error("busy timer reloaded while still counting");

endmodule

// ==== design/md_control.sv ====
`timescale 1ns/1ps
`include "md_settings.svh"

module md_control import md_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  md_req_t                req,
	input  logic                   last,
	output logic                   start,
	output logic                   load,
	output logic [`MD_TIMER_W-1:0] load_len,
	output logic                   wr_hi,
	output logic                   wr_lo,
	output logic                   commit,
	output logic                   stall
);

	typedef enum logic {
		st_idle,
		st_run
	} state_e;

	localparam logic [`MD_TIMER_W-1:0] mult_len = `MD_MULT_CYCLES;
	localparam logic [`MD_TIMER_W-1:0] div_len  = `MD_DIV_CYCLES;

	state_e state;
	logic   is_mul;
	logic   is_div;

	assign is_mul = (req.op == op_mult) || (req.op == op_multu);
	assign is_div = (req.op == op_div) || (req.op == op_divu);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else if (start) begin
			state <= st_run;
		end else if (commit) begin
			state <= st_idle;
		end
	end

	// Launch only from IDLE so instructions seen in RUN are ignored
	assign start    = (state == st_idle) && (is_mul || is_div);
	assign load     = start;
	assign load_len = is_div ? div_len : mult_len;

	// Direct writes are dropped while an operation is in flight
	assign wr_hi = (state == st_idle) && (req.op == op_mthi);
	assign wr_lo = (state == st_idle) && (req.op == op_mtlo);

	assign commit = (state == st_run) && last;

	// Stall rises with the start cycle and covers all of RUN
	assign stall = start || (state == st_run);

	////////////////////////////////
	// Checks
	////////////////////////////////

	// Every launch ends in a commit within the longest latency
	a_start_commits: assert property (
		@(posedge clk) disable iff (rst)
		start |-> ##[1:`MD_DIV_CYCLES] commit
	) else $error("operation started but never committed");

	// Divide commits exactly its latency after the launch
	a_div_latency: assert property (
		@(posedge clk) disable iff (rst)
		start && is_div |-> ##`MD_DIV_CYCLES commit
	) else $error("divide committed at the wrong cycle");

endmodule

// ==== design/md_decoder.sv ====
`timescale 1ns/1ps
`include "md_settings.svh"

module md_decoder import md_pkg::*; (
	input  logic [31:0]         instr,
	input  logic [`MD_XLEN-1:0] data1,
	input  logic [`MD_XLEN-1:0] data2,
	output md_req_t             req
);

	logic [5:0] opcode;
	logic [5:0] funct;
	md_op_e     op;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	// Only the SPECIAL class carries HI/LO work
	always_comb begin
		op = op_none;
		if (opcode == opcode_special) begin
			case (funct)
				funct_mult:  op = op_mult;
				funct_multu: op = op_multu;
				funct_div:   op = op_div;
				funct_divu:  op = op_divu;
				funct_mfhi:  op = op_mfhi;
				funct_mflo:  op = op_mflo;
				funct_mthi:  op = op_mthi;
				funct_mtlo:  op = op_mtlo;
				default:     op = op_none;
			endcase
		end
	end

	// Operands pass straight into the request
	always_comb begin
		req.op = op;
		req.a  = data1;
		req.b  = data2;
	end

endmodule

// ==== design/md_hilo_regs.sv ====
`timescale 1ns/1ps
`include "md_settings.svh"

module md_hilo_regs import md_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  md_req_t             req,
	input  logic                wr_hi,
	input  logic                wr_lo,
	input  logic                commit,
	input  md_result_t          pending,
	output logic [`MD_XLEN-1:0] hl_data
);

	logic [`MD_XLEN-1:0] hi_q;
	logic [`MD_XLEN-1:0] lo_q;

	// Architectural HI
	always_ff @(posedge clk) begin
		if (rst) begin
			hi_q <= '0;
		end else if (commit) begin
			hi_q <= pending.hi;
		end else if (wr_hi) begin
			hi_q <= req.a;
		end
	end

	// Architectural LO
	always_ff @(posedge clk) begin
		if (rst) begin
			lo_q <= '0;
		end else if (commit) begin
			lo_q <= pending.lo;
		end else if (wr_lo) begin
			lo_q <= req.a;
		end
	end

	// Read port, same cycle as the move-from
	always_comb begin
		case (req.op)
			op_mfhi: hl_data = hi_q;
			op_mflo: hl_data = lo_q;
			default: hl_data = '0;
		endcase
	end

	// Direct writes only happen in IDLE, commit only in RUN
	a_no_overlap: assert property (
		@(posedge clk) disable iff (rst)
		!(commit && (wr_hi || wr_lo))
	) else $error("commit collided with a direct HI/LO write");

endmodule

// ==== design/md_pkg.sv ====
`include "md_settings.svh"

package md_pkg;

	////////////////////////////////
	// Instruction field codes
	////////////////////////////////
	localparam logic [5:0] opcode_special = 6'b000000;

	localparam logic [5:0] funct_mfhi  = 6'b010000;
	localparam logic [5:0] funct_mthi  = 6'b010001;
	localparam logic [5:0] funct_mflo  = 6'b010010;
	localparam logic [5:0] funct_mtlo  = 6'b010011;
	localparam logic [5:0] funct_mult  = 6'b011000;
	localparam logic [5:0] funct_multu = 6'b011001;
	localparam logic [5:0] funct_div   = 6'b011010;
	localparam logic [5:0] funct_divu  = 6'b011011;

	////////////////////////////////
	// Decoded operation and payloads
	////////////////////////////////
	typedef enum logic [3:0] {
		op_none,
		op_mult,
		op_multu,
		op_div,
		op_divu,
		op_mfhi,
		op_mflo,
		op_mthi,
		op_mtlo
	} md_op_e;

	typedef struct packed {
		md_op_e                op;
		logic [`MD_XLEN-1:0] a;
		logic [`MD_XLEN-1:0] b;
	} md_req_t;

	typedef struct packed {
		logic [`MD_XLEN-1:0] hi;
		logic [`MD_XLEN-1:0] lo;
	} md_result_t;

endpackage

// ==== design/md_settings.svh ====
`ifndef MD_SETTINGS_SVH
`define MD_SETTINGS_SVH

// Operand and HI/LO register width
`define MD_XLEN 32

// Busy cycles that follow the start cycle
`define MD_MULT_CYCLES 5
`define MD_DIV_CYCLES 10

// Busy counter width, wide enough for the divide latency
`define MD_TIMER_W 4

`endif

// ==== design/md_unit.sv ====
`timescale 1ns/1ps
`include "md_settings.svh"

module md_unit import md_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic [31:0]         instr,
	input  logic [`MD_XLEN-1:0] data1,
	input  logic [`MD_XLEN-1:0] data2,
	output logic [`MD_XLEN-1:0] hl_data,
	output logic                stall
);

	md_req_t                req;
	md_result_t             pending;
	logic                   start;
	logic                   load;
	logic [`MD_TIMER_W-1:0] load_len;
	logic                   last;
	logic                   wr_hi;
	logic                   wr_lo;
	logic                   commit;

	////////////////////////////////
	// Decode and control
	////////////////////////////////
	md_decoder decoder_i (
		.instr (instr),
		.data1 (data1),
		.data2 (data2),
		.req   (req)
	);

	md_control control_i (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.last     (last),
		.start    (start),
		.load     (load),
		.load_len (load_len),
		.wr_hi    (wr_hi),
		.wr_lo    (wr_lo),
		.commit   (commit),
		.stall    (stall)
	);

	md_busy_timer timer_i (
		.clk      (clk),
		.rst      (rst),
		.load     (load),
		.load_len (load_len),
		.last     (last)
	);

	////////////////////////////////
	// Datapath
	////////////////////////////////
	md_arith arith_i (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.req     (req),
		.pending (pending)
	);

	md_hilo_regs hilo_i (
		.clk     (clk),
		.rst     (rst),
		.req     (req),
		.wr_hi   (wr_hi),
		.wr_lo   (wr_lo),
		.commit  (commit),
		.pending (pending),
		.hl_data (hl_data)
	);

endmodule

// ==== dv/md_unit_tb.sv ====
`timescale 1ns/1ps
`include "md_settings.svh"

module md_unit_tb import md_pkg::*; ();

	// Directed part takes a few hundred cycles and the random mix
	// at most 200 operations of 11 cycles each
	localparam int max_cycles = 4000;
	localparam int random_ops = 200;

	logic                clk = 1'b0;
	logic                rst;
	logic [31:0]         instr;
	logic [`MD_XLEN-1:0] data1;
	logic [`MD_XLEN-1:0] data2;
	logic [`MD_XLEN-1:0] hl_data;
	logic                stall;

	logic [15:0] lfsr = 16'd47966;
	int          cycle_count = 0;
	int          error_count = 0;
	string       test_name;

	md_op_e              cur_op;
	logic                exp_stall;
	logic [`MD_XLEN-1:0] exp_hl;
	logic                model_run;
	int                  model_count;
	logic [`MD_XLEN-1:0] model_hi;
	logic [`MD_XLEN-1:0] model_lo;
	md_result_t          pend;

	md_unit dut_i (
		.clk     (clk),
		.rst     (rst),
		.instr   (instr),
		.data1   (data1),
		.data2   (data2),
		.hl_data (hl_data),
		.stall   (stall)
	);

	always #5 clk = ~clk;

	////////////////////////////////
	// Helpers
	////////////////////////////////

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return value;
	endfunction

	// Avoids zero and the signed overflow case
	function automatic logic [31:0] draw_divisor(input logic signed_op, input logic [31:0] a);
		logic [31:0] b;
		b = rand_bits(32);
		while (b == '0 || (signed_op && a == 32'h8000_0000 && b == 32'hffff_ffff)) begin
			b = rand_bits(32);
		end
		return b;
	endfunction

	function automatic logic [31:0] make_instr(input logic [5:0] opcode, input logic [5:0] funct);
		return {opcode, 5'd8, 5'd9, 5'd0, 5'd0, funct};
	endfunction

	function automatic logic [31:0] special_instr(input logic [5:0] funct);
		return make_instr(opcode_special, funct);
	endfunction

	function automatic md_op_e decode_op(input logic [31:0] word);
		if (word[31:26] != opcode_special) begin
			return op_none;
		end
		case (word[5:0])
			funct_mult:  return op_mult;
			funct_multu: return op_multu;
			funct_div:   return op_div;
			funct_divu:  return op_divu;
			funct_mfhi:  return op_mfhi;
			funct_mflo:  return op_mflo;
			funct_mthi:  return op_mthi;
			funct_mtlo:  return op_mtlo;
			default:     return op_none;
		endcase
	endfunction

	function automatic logic is_div_op(input md_op_e op);
		return op == op_div || op == op_divu;
	endfunction

	function automatic logic is_long_op(input md_op_e op);
		return op == op_mult || op == op_multu || is_div_op(op);
	endfunction

	// HI/LO pair as the ISA defines it
	function automatic md_result_t expected_result(input md_op_e op, input logic [31:0] a,
			input logic [31:0] b);
		longint          sa;
		longint          sb;
		longint          sp;
		longint unsigned ua;
		longint unsigned ub;
		longint unsigned up;
		int              ia;
		int              ib;
		md_result_t      res;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		ua = {32'd0, a};
		ub = {32'd0, b};
		ia = a;
		ib = b;
		res = '0;
		case (op)
			op_mult: begin
				sp = sa * sb;
				res = {sp[63:32], sp[31:0]};
			end
			op_multu: begin
				up = ua * ub;
				res = {up[63:32], up[31:0]};
			end
			op_div: begin
				res.lo = ia / ib;
				res.hi = ia % ib;
			end
			op_divu: begin
				res.lo = a / b;
				res.hi = a % b;
			end
			default: res = '0;
		endcase
		return res;
	endfunction

	task automatic abort_run();
		$display("tests failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic mismatch_error(input string check, input logic [31:0] expected,
			input logic [31:0] actual);
		error_count = error_count + 1;
		$display("Fail %s %s expected %h actual %h", test_name, check, expected, actual);
		abort_run();
	endtask

	////////////////////////////////
	// Reference model
	////////////////////////////////
	assign cur_op    = decode_op(instr);
	assign exp_stall = model_run || is_long_op(cur_op);

	always_comb begin
		case (cur_op)
			op_mfhi: exp_hl = model_hi;
			op_mflo: exp_hl = model_lo;
			default: exp_hl = '0;
		endcase
	end

	always @(posedge clk) begin
		if (rst) begin
			model_run   <= 1'b0;
			model_count <= 0;
			model_hi    <= '0;
			model_lo    <= '0;
			pend        <= '0;
		end else if (model_run) begin
			// Instructions seen while busy have no effect
			if (model_count == 1) begin
				model_hi  <= pend.hi;
				model_lo  <= pend.lo;
				model_run <= 1'b0;
			end else begin
				model_count <= model_count - 1;
			end
		end else if (is_long_op(cur_op)) begin
			pend        <= expected_result(cur_op, data1, data2);
			model_run   <= 1'b1;
			model_count <= is_div_op(cur_op) ? `MD_DIV_CYCLES : `MD_MULT_CYCLES;
		end else if (cur_op == op_mthi) begin
			model_hi <= data1;
		end else if (cur_op == op_mtlo) begin
			model_lo <= data1;
		end
	end

	a_stall: assert property (@(posedge clk) disable iff (rst) stall == exp_stall)
		else mismatch_error("stall", 32'($sampled(exp_stall)), 32'($sampled(stall)));

	a_hl_data: assert property (@(posedge clk) disable iff (rst) hl_data == exp_hl)
		else mismatch_error("hl_data", $sampled(exp_hl), $sampled(hl_data));

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout after %0d cycles, the stimulus never finished", max_cycles);
			abort_run();
		end
	end

	////////////////////////////////
	// Stimulus
	////////////////////////////////

	// One instruction for one cycle
	task automatic present(input logic [31:0] word, input logic [31:0] a, input logic [31:0] b);
		@(posedge clk);
		instr <= word;
		data1 <= a;
		data2 <= b;
		@(negedge clk);
	endtask

	// Held while the unit stalls as the pipeline would do
	task automatic hold_long(input logic [31:0] word, input logic [31:0] a, input logic [31:0] b);
		int need;
		int held;
		need = is_div_op(decode_op(word)) ? `MD_DIV_CYCLES + 1 : `MD_MULT_CYCLES + 1;
		held = 0;
		@(posedge clk);
		instr <= word;
		data1 <= a;
		data2 <= b;
		while (held < need) begin
			@(negedge clk);
			if (stall) begin
				held = held + 1;
			end
		end
	endtask

	task automatic run_and_read(input logic [5:0] funct, input logic [31:0] a,
			input logic [31:0] b);
		hold_long(special_instr(funct), a, b);
		present(special_instr(funct_mfhi), '0, '0);
		present(special_instr(funct_mflo), '0, '0);
	endtask

	task automatic wait_idle();
		while (stall) begin
			@(negedge clk);
		end
	endtask

	task automatic random_step();
		logic [31:0] pick;
		logic [31:0] a;
		logic [31:0] b;
		pick = rand_bits(3);
		a = rand_bits(32);
		b = rand_bits(32);
		case (pick[2:0])
			3'd0: hold_long(special_instr(funct_mult), a, b);
			3'd1: hold_long(special_instr(funct_multu), a, b);
			3'd2: hold_long(special_instr(funct_div), a, draw_divisor(1'b1, a));
			3'd3: hold_long(special_instr(funct_divu), a, draw_divisor(1'b0, a));
			3'd4: present(special_instr(funct_mfhi), a, b);
			3'd5: present(special_instr(funct_mflo), a, b);
			3'd6: present(special_instr(funct_mthi), a, b);
			default: present(special_instr(funct_mtlo), a, b);
		endcase
	endtask

	initial begin
		logic [31:0] wa;
		logic [31:0] wb;
		rst = 1'b1;
		instr = '0;
		data1 = '0;
		data2 = '0;
		test_name = "reset";
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		present(special_instr(funct_mfhi), '0, '0);
		present(special_instr(funct_mflo), '0, '0);
		// SPECIAL add and then a non-SPECIAL word carrying the mfhi funct
		present(special_instr(6'b100000), 32'h1234_5678, 32'h9abc_def0);
		present(make_instr(6'b001000, funct_mfhi), '0, '0);

		test_name = "direct_write";
		wa = rand_bits(32);
		wb = rand_bits(32);
		present(special_instr(funct_mthi), wa, '0);
		present(special_instr(funct_mtlo), wb, '0);
		present(special_instr(funct_mfhi), '0, '0);
		present(special_instr(funct_mflo), '0, '0);

		test_name = "multiply";
		run_and_read(funct_mult, 32'hffff_fffd, 32'd7);
		run_and_read(funct_multu, 32'hffff_ffff, 32'hffff_ffff);
		run_and_read(funct_mult, 32'h8000_0000, 32'h8000_0000);
		run_and_read(funct_mult, 32'h7fff_ffff, 32'h8000_0000);
		run_and_read(funct_multu, rand_bits(32), rand_bits(32));
		run_and_read(funct_mult, rand_bits(32), rand_bits(32));

		test_name = "divide";
		run_and_read(funct_div, 32'hffff_fff9, 32'd2);
		run_and_read(funct_div, 32'd100, 32'hffff_fff9);
		run_and_read(funct_divu, 32'hffff_fff0, 32'd3);
		run_and_read(funct_divu, 32'd5, 32'd9);
		wa = rand_bits(32);
		run_and_read(funct_div, wa, draw_divisor(1'b1, wa));
		wa = rand_bits(32);
		run_and_read(funct_divu, wa, draw_divisor(1'b0, wa));

		// Reads and writes inside a divide run
		test_name = "during_run";
		present(special_instr(funct_mthi), 32'h0bad_cafe, '0);
		present(special_instr(funct_mtlo), 32'h1357_9bdf, '0);
		present(special_instr(funct_div), 32'd1000, 32'd7);
		present(special_instr(funct_mfhi), '0, '0);
		present(special_instr(funct_mflo), '0, '0);
		present(special_instr(funct_mthi), 32'hdead_beef, '0);
		present(special_instr(funct_mtlo), 32'hfeed_f00d, '0);
		present(special_instr(funct_mult), 32'd3, 32'd5);
		present(special_instr(funct_mfhi), '0, '0);
		present(special_instr(6'b100000), '0, '0);
		wait_idle();
		present(special_instr(funct_mfhi), '0, '0);
		present(special_instr(funct_mflo), '0, '0);

		test_name = "random_mix";
		for (int n = 0; n < random_ops; n++) begin
			random_step();
		end
		present(special_instr(funct_mfhi), '0, '0);
		present(special_instr(funct_mflo), '0, '0);

		test_name = "done";
		repeat (2) @(negedge clk);
		if (error_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

// ==== filelist.f ====
+incdir+design
design/md_pkg.sv
design/md_decoder.sv
design/md_busy_timer.sv
design/md_control.sv
design/md_arith.sv
design/md_hilo_regs.sv
design/md_unit.sv
dv/md_unit_tb.sv
